//--- logic/bits_pkg.sv
package bits_pkg;

  // Window and memory word geometry
  localparam int WINDOW_BITS = 256;
  localparam int WORD_BITS = 128;
  localparam int WORD_BYTES = WORD_BITS / 8;

  // Fill level runs from 0 to WINDOW_BITS inclusive
  localparam int LEVEL_BITS = 9;

  typedef logic [WINDOW_BITS-1:0] window_t;
  typedef logic [LEVEL_BITS-1:0] level_t;

  // Codes from the decoder FSM
  // Anything above HOLD is idle and lets the memory word in
  typedef enum logic [4:0] {
    LIT_1 = 5'h00,
    LIT_2 = 5'h01,
    LIT_3 = 5'h02,
    LIT_4 = 5'h03,
    LIT_5 = 5'h04,
    LIT_6 = 5'h05,
    LIT_7 = 5'h06,
    LIT_8 = 5'h07,
    LIT_9 = 5'h08,
    LIT_10 = 5'h09,
    LIT_11 = 5'h0A,
    LIT_12 = 5'h0B,
    LIT_13 = 5'h0C,
    LIT_14 = 5'h0D,
    LIT_15 = 5'h0E,
    LIT_16 = 5'h0F,
    OP_TYPE1 = 5'h10,
    OP_TYPE2 = 5'h11,
    HOLD = 5'h12
  } consume_code_t;

  // Word from the instruction memory controller, strobes active low
  typedef struct packed {
    logic req_b;
    logic ack_b;
    logic [WORD_BYTES-1:0] valid_bytes;
    logic [WORD_BITS-1:0] word;
  } mem_fill_t;

  // Bits removed from the top of the window for one consume code
  function automatic level_t consume_size(input consume_code_t code);
    level_t size;
    size = '0;
    if (code <= LIT_16)
    begin
      // 6-bit literal header plus one 5-bit group per nibble
      size = level_t'(11 + 5 * int'(code));
    end
    else if (code == OP_TYPE1)
    begin
      size = level_t'(22);
    end
    else if (code == OP_TYPE2)
    begin
      size = level_t'(18);
    end
    return size;
  endfunction

  function automatic logic is_consume(input consume_code_t code);
    return (code <= OP_TYPE2);
  endfunction

endpackage

//--- logic/bits_level_counter.sv
module bits_level_counter
  import bits_pkg::*;
#(
  parameter int WINDOW_BITS = bits_pkg::WINDOW_BITS,
  parameter int WORD_BITS = bits_pkg::WORD_BITS
)
(
  input logic clk,
  input logic resetB,

  input consume_code_t code,
  input logic append_en,
  input logic [WORD_BYTES-1:0] valid_bytes,

  output level_t level,
  output logic space_available
);

  // Room for one more full word at or below this level
  localparam level_t SPACE_LIMIT = level_t'(WINDOW_BITS - WORD_BITS);

  // Enough bits to count every valid byte flag
  localparam int COUNT_BITS = $clog2(WORD_BYTES + 1);

  logic [COUNT_BITS-1:0] byte_count;
  level_t append_bits;
  level_t drop_bits;
  level_t level_q;
  level_t level_next;

  // Population count of the valid byte flags
  always_comb
  begin
    byte_count = '0;
    for (int i = 0; i < WORD_BYTES; i++)
    begin
      byte_count = byte_count + COUNT_BITS'(valid_bytes[i]);
    end
  end

  // Eight bits per valid byte
  assign append_bits = level_t'({byte_count, 3'b000});

  assign drop_bits = consume_size(code);

  // Consume has priority, append_en is already low on a consume code
  always_comb
  begin
    level_next = level_q;
    if (is_consume(code))
    begin
      level_next = level_q - drop_bits;
    end
    else if (append_en)
    begin
      level_next = level_q + append_bits;
    end
  end

  always_ff @(posedge clk or negedge resetB)
  begin
    if (!resetB)
    begin
      level_q <= '0;
    end
    else
    begin
      level_q <= level_next;
    end
  end

  assign level = level_q;

  // Decoded straight from the register
  assign space_available = (level_q <= SPACE_LIMIT);

endmodule

//--- logic/bits_window_shifter.sv
module bits_window_shifter
  import bits_pkg::*;
#(
  parameter int WINDOW_BITS = bits_pkg::WINDOW_BITS,
  parameter int WORD_BITS = bits_pkg::WORD_BITS
)
(
  input logic clk,
  input logic resetB,

  input consume_code_t code,
  input logic append_en,

  // Current fill level, also the insertion offset from the top
  input level_t level,
  input logic [WORD_BITS-1:0] word,

  output window_t window
);

  // Zero bits below the word when it sits at the top of the window
  localparam int PAD_BITS = WINDOW_BITS - WORD_BITS;

  window_t window_q;
  window_t window_next;

  // Consume path
  level_t drop_bits;
  window_t shifted;

  // Append path
  logic [WINDOW_BITS-1:0] word_at_top;
  window_t keep_mask;
  window_t placed_word;
  window_t inserted;

  assign drop_bits = consume_size(code);

  // Oldest bits leave at the top, zeros enter at the bottom
  assign shifted = window_q << drop_bits;

  assign word_at_top = {word, {PAD_BITS{1'b0}}};

  // Ones over the bits already held, zeros from the offset down
  assign keep_mask = ~({WINDOW_BITS{1'b1}} >> level);

  // Word lands directly below the held bits
  assign placed_word = word_at_top >> level;

  // Stale bits under the level are dropped along with anything under the word
  assign inserted = (window_q & keep_mask) | placed_word;

  always_comb
  begin
    window_next = window_q;
    if (is_consume(code))
    begin
      window_next = shifted;
    end
    else if (append_en)
    begin
      window_next = inserted;
    end
  end

  always_ff @(posedge clk or negedge resetB)
  begin
    if (!resetB)
    begin
      window_q <= '0;
    end
    else
    begin
      window_q <= window_next;
    end
  end

  assign window = window_q;

endmodule

//--- logic/bits_window_top.sv
module bits_window_top
  import bits_pkg::*;
#(
  parameter int WINDOW_BITS = bits_pkg::WINDOW_BITS,
  parameter int WORD_BITS = bits_pkg::WORD_BITS
)
(
  input logic clk,
  input logic resetB,

  // Instruction memory controller
  input mem_fill_t fill,

  // Decoder FSM
  input consume_code_t code,

  output window_t window,
  output logic space_available
);

  // Highest level at which a whole word still fits
  localparam level_t APPEND_LIMIT = level_t'(WINDOW_BITS - WORD_BITS);

  level_t level;
  logic strobes_low;
  logic code_allows;
  logic level_allows;
  logic append_en;

  assign strobes_low = ~fill.req_b & ~fill.ack_b;

  // HOLD freezes everything, a consume takes the cycle
  assign code_allows = !is_consume(code) && (code != HOLD);

  assign level_allows = (level <= APPEND_LIMIT);

  // One append decision shared by the counter and the shifter
  assign append_en = strobes_low & code_allows & level_allows;

  bits_level_counter #(
    .WINDOW_BITS (WINDOW_BITS),
    .WORD_BITS (WORD_BITS)
  ) i_level_counter (
    .clk (clk),
    .resetB (resetB),
    .code (code),
    .append_en (append_en),
    .valid_bytes (fill.valid_bytes),
    .level (level),
    .space_available (space_available)
  );

  bits_window_shifter #(
    .WINDOW_BITS (WINDOW_BITS),
    .WORD_BITS (WORD_BITS)
  ) i_window_shifter (
    .clk (clk),
    .resetB (resetB),
    .code (code),
    .append_en (append_en),
    .level (level),
    .word (fill.word),
    .window (window)
  );

endmodule

//--- testbench/bits_window_chk.sv
module bits_window_chk
  import bits_pkg::*;
#(
  parameter int WINDOW_BITS = bits_pkg::WINDOW_BITS
)
(
  input logic clk,
  input logic resetB,
  input consume_code_t code,
  input level_t level
);

  // The decoder never takes more bits than the window holds
  consume_fits: assert property (@(posedge clk) disable iff (!resetB)
    is_consume(code) |-> (consume_size(code) <= level))
    else $error("Consume of %0d bits with only %0d bits held", consume_size(code), level);

  level_in_range: assert property (@(posedge clk) disable iff (!resetB)
    level <= level_t'(WINDOW_BITS))
    else $error("Level %0d above the window width", level);

  level_after_reset: assert property (@(posedge clk)
    $rose(resetB) |-> (level == '0))
    else $error("Level %0d right after reset release", level);

endmodule

bind bits_level_counter bits_window_chk #(
  .WINDOW_BITS (WINDOW_BITS)
) i_chk (
  .clk (clk),
  .resetB (resetB),
  .code (code),
  .level (level)
);

//--- testbench/bits_window_tb.sv
module bits_window_tb
  import bits_pkg::*;
();

  localparam int CLK_HALF = 2;
  localparam int RESET_CYCLES = 4;
  localparam int MAX_LINES = 1000;
  localparam int WATCHDOG_CYCLES = 2000;
  localparam string STIM_FILE = "testbench/bits_window_stim.txt";

  // Highest level at which the model still takes a word
  localparam level_t APPEND_MAX = level_t'(WINDOW_BITS - WORD_BITS);

  logic clk;
  logic resetB;
  mem_fill_t fill;
  consume_code_t code;
  window_t window;
  logic space_available;

  // Bits consumed by codes 0x00 to 0x11
  int size_table [18] = '{11, 16, 21, 26, 31, 36, 41, 46,
                          51, 56, 61, 66, 71, 76, 81, 86, 22, 18};

  int mismatch_count;
  int failure_count;

  // Reference model state after the last line applied
  window_t model_window;
  level_t model_level;

  bits_window_top #(
    .WINDOW_BITS (WINDOW_BITS),
    .WORD_BITS (WORD_BITS)
  ) i_dut (
    .clk (clk),
    .resetB (resetB),
    .fill (fill),
    .code (code),
    .window (window),
    .space_available (space_available)
  );

  initial clk = 1'b0;

  always #CLK_HALF clk = ~clk;

  task automatic check_window(input string name, input window_t expected, input window_t actual);
    if (actual !== expected)
    begin
      mismatch_count++;
      $display("ERR %s window expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic check_space(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      mismatch_count++;
      $display("ERR %s space_available expected %b actual %b", name, expected, actual);
    end
  endtask

  task automatic check_level(input string name, input level_t expected, input level_t actual);
    if (actual !== expected)
    begin
      mismatch_count++;
      $display("ERR %s level expected %0d actual %0d", name, expected, actual);
    end
  endtask

  // Held bits stay on top, the word goes right under them, the rest is cleared
  function automatic window_t place_word(input window_t held, input level_t offset,
                                         input logic [WORD_BITS-1:0] w);
    window_t keep;
    window_t placed;
    int shift_amt;
    shift_amt = WINDOW_BITS - int'(offset);
    keep = (held >> shift_amt) << shift_amt;
    placed = {w, {(WINDOW_BITS - WORD_BITS){1'b0}}} >> offset;
    return keep | placed;
  endfunction

  task automatic model_step(input logic [4:0] c, input mem_fill_t f);
    int used;
    int added;
    if (c <= 5'h11)
    begin
      used = size_table[c];
      model_window = model_window << used;
      model_level = model_level - level_t'(used);
    end
    else if (c != 5'h12 && !f.req_b && !f.ack_b && model_level <= APPEND_MAX)
    begin
      added = 8 * $countones(f.valid_bytes);
      model_window = place_word(model_window, model_level, f.word);
      model_level = model_level + level_t'(added);
    end
  endtask

  initial
  begin
    int fd;
    int lines;
    int got;
    string text;
    string name;
    string prev_name;
    logic have_expected;
    logic [4:0] f_code;
    logic f_req_b;
    logic f_ack_b;
    logic [WORD_BYTES-1:0] f_valid;
    logic [WORD_BITS-1:0] f_word;
    level_t f_level;
    logic f_space;
    window_t exp_window;
    level_t exp_level;
    logic exp_space;

    mismatch_count = 0;
    failure_count = 0;
    model_window = '0;
    model_level = '0;
    have_expected = 1'b0;
    resetB = 1'b0;
    code = consume_code_t'(5'h1F);
    fill = '{req_b: 1'b1, ack_b: 1'b1, valid_bytes: '0, word: '0};

    repeat (RESET_CYCLES) @(posedge clk);
    resetB <= 1'b1;
    @(negedge clk);
    check_window("reset", '0, window);
    check_space("reset", 1'b1, space_available);
    check_level("reset", '0, i_dut.level);

    fd = $fopen(STIM_FILE, "r");
    if (fd == 0)
    begin
      failure_count++;
      $display("Could not open stimulus file %s", STIM_FILE);
    end

    lines = 0;
    while (fd != 0 && !$feof(fd) && lines < MAX_LINES)
    begin
      got = $fgets(text, fd);
      lines++;
      // Nothing was read at the end of the file
      if (got == 0)
      begin
        text = "";
      end
      got = $sscanf(text, "%h %h %h %h %h %h %h", f_code, f_req_b, f_ack_b,
                    f_valid, f_word, f_level, f_space);
      // Comment and blank lines do not scan
      if (got == 7)
      begin
        name = $sformatf("line%0d_code%h", lines, f_code);
        @(posedge clk);
        code <= consume_code_t'(f_code);
        fill <= '{req_b: f_req_b, ack_b: f_ack_b, valid_bytes: f_valid, word: f_word};
        @(negedge clk);
        // Results of the previous line are out after this edge
        if (have_expected)
        begin
          check_window(prev_name, exp_window, window);
          check_space(prev_name, exp_space, space_available);
          check_level(prev_name, exp_level, i_dut.level);
        end
        model_step(f_code, '{req_b: f_req_b, ack_b: f_ack_b, valid_bytes: f_valid,
                             word: f_word});
        if (model_level !== f_level)
        begin
          failure_count++;
          $display("Stimulus file expects level %0d at %s but the model reaches %0d",
                   f_level, name, model_level);
        end
        exp_window = model_window;
        exp_level = f_level;
        exp_space = f_space;
        prev_name = name;
        have_expected = 1'b1;
      end
    end

    if (lines >= MAX_LINES)
    begin
      failure_count++;
      $display("Stimulus file did not end within %0d lines", MAX_LINES);
    end
    if (fd != 0)
    begin
      $fclose(fd);
    end

    // One idle cycle to collect the last line
    @(posedge clk);
    code <= consume_code_t'(5'h1F);
    fill <= '{req_b: 1'b1, ack_b: 1'b1, valid_bytes: '0, word: '0};
    @(negedge clk);
    if (have_expected)
    begin
      check_window(prev_name, exp_window, window);
      check_space(prev_name, exp_space, space_available);
      check_level(prev_name, exp_level, i_dut.level);
    end

    $display("Done: %0d value errors, %0d other failures", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0)
    begin
      $display("NO ERRORS");
    end
    else
    begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial
  begin
    int waited;
    waited = 0;
    while (waited < WATCHDOG_CYCLES)
    begin
      @(posedge clk);
      waited++;
    end
    $display("Simulation did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- testbench/bits_window_stim.txt
// code req_b ack_b valid_bytes word | expected level, expected space_available
// All fields hex, one line per clock cycle
1f 1 1 ffff a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 000 1
1f 0 1 ffff 5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a 000 1
1f 1 0 ffff 0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f 000 1
1f 0 0 ffff 0123456789abcdeffedcba9876543210 080 1
12 0 0 ffff deadbeefcafef00d0badc0de12345678 080 1
00 0 0 ffff 11112222333344445555666677778888 075 1
1f 0 0 00ff 89abcdef0123456776543210fedcba98 0b5 0
1f 0 0 ffff ffffffffffffffffffffffffffffffff 0b5 0
13 0 0 ffff 13579bdf02468ace13579bdf02468ace 0b5 0
12 1 1 0000 00000000000000000000000000000000 0b5 0
01 1 1 0000 00000000000000000000000000000000 0a5 0
02 1 1 0000 00000000000000000000000000000000 090 0
03 1 1 0000 00000000000000000000000000000000 076 1
1f 0 0 0f0f c3d2e1f00f1e2d3c4b5a69788796a5b4 0b6 0
04 1 1 0000 00000000000000000000000000000000 097 0
05 1 0 ffff 77777777777777777777777777777777 073 1
1f 0 0 ffff 3c3c3c3cc3c3c3c3969696966969a5a5 0f3 0
06 1 1 0000 00000000000000000000000000000000 0ca 0
07 0 1 ffff 22222222222222222222222222222222 09c 0
08 1 1 0000 00000000000000000000000000000000 069 1
1f 0 0 ffff fedcba98765432100123456789abcdef 0e9 0
09 1 1 0000 00000000000000000000000000000000 0b1 0
0a 1 1 0000 00000000000000000000000000000000 074 1
1f 0 0 7fff 8000000100000002400000030000000c 0ec 0
0b 1 1 0000 00000000000000000000000000000000 0aa 0
0c 1 1 0000 00000000000000000000000000000000 063 1
1f 0 0 ffff 6b6b6b6b5c5c5c5c4d4d4d4d3e3e3e3e 0e3 0
0d 1 1 0000 00000000000000000000000000000000 097 0
1e 0 0 ffff abababababababababababababababab 097 0
0e 1 1 0000 00000000000000000000000000000000 046 1
1f 0 0 ffff f0e1d2c3b4a5968778695a4b3c2d1e0f 0c6 0
0f 1 1 0000 00000000000000000000000000000000 070 1
10 0 0 ffff 99999999999999999999999999999999 05a 1
11 1 1 0000 00000000000000000000000000000000 048 1
1f 0 0 0001 00000000000000000000000000000081 050 1
1f 0 0 8001 7e00000000000000000000000000007e 060 1
1f 0 0 ffff 2468ace013579bdf2468ace013579bdf 0e0 0
0f 1 1 0000 00000000000000000000000000000000 08a 0
0e 1 1 0000 00000000000000000000000000000000 039 1
1f 0 0 ffff 55aa55aa33cc33cc0ff00ff000ff00ff 0b9 0
11 0 0 ffff 44444444444444444444444444444444 0a7 0
0c 1 1 0000 00000000000000000000000000000000 060 1
1f 0 0 ffff cafebabe8badf00dfeedface0ddba11a 0e0 0
0f 1 1 0000 00000000000000000000000000000000 08a 0
0f 1 1 0000 00000000000000000000000000000000 034 1
10 1 1 0000 00000000000000000000000000000000 01e 1
00 1 1 0000 00000000000000000000000000000000 013 1
01 1 1 0000 00000000000000000000000000000000 003 1
1f 0 0 ffff 1f2e3d4c5b6a79880123456789abcdef 083 0
1f 0 0 ffff eeeeeeeeeeeeeeeeeeeeeeeeeeeeeeee 083 0
00 1 1 0000 00000000000000000000000000000000 078 1
1f 0 0 0100 00000000000000000000bd0000000000 080 1
1f 0 0 ffff 9e3779b97f4a7c15f39cc0605cedc834 100 0
12 0 0 ffff 66666666666666666666666666666666 100 0
1f 1 0 ffff 88888888888888888888888888888888 100 0
0f 1 1 0000 00000000000000000000000000000000 0aa 0
0f 1 1 0000 00000000000000000000000000000000 054 1
0d 1 1 0000 00000000000000000000000000000000 008 1
1f 0 0 f000 d00dfeed00000000000000000000beef 028 1
1f 0 1 ffff 31415926535897932384626433832795 028 1

//--- filelist.f
logic/bits_pkg.sv
logic/bits_level_counter.sv
logic/bits_window_shifter.sv
logic/bits_window_top.sv
testbench/bits_window_chk.sv
testbench/bits_window_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the bits window testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert \
  -f filelist.f \
  --top-module bits_window_tb \
  -Mdir "$BUILD_DIR" \
  -o bits_window_sim

status=0
"./$BUILD_DIR/bits_window_sim" > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -qx "NO ERRORS" "$LOG"; then
  echo "Simulation passed"
  exit 0
fi

echo "Simulation failed, exit status $status"
exit 1
